//--- Bender.yml
package:
  name: beat_classifier

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/beatPkg.sv
      - source/sampleWriter.sv
      - source/ramArbiter.sv
      - source/windowRam.sv
      - source/treeNodeRom.sv
      - source/treeWalker.sv
      - source/beatClassifierTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/beatClassifier_asserts.sv
      - test/beatClassifier_tb.sv

//--- flist.f
+incdir+include
source/beatPkg.sv
source/sampleWriter.sv
source/ramArbiter.sv
source/windowRam.sv
source/treeNodeRom.sv
source/treeWalker.sv
source/beatClassifierTop.sv
test/beatClassifier_asserts.sv
test/beatClassifier_tb.sv

//--- include/beat_macros.svh
`ifndef BEAT_MACROS_SVH
`define BEAT_MACROS_SVH

// Sample and window geometry
`define SAMPLE_W    13
`define WINDOW_LEN  187

// 256 slots leave spare room past one window
`define RAM_ADDR_W  8

// Decision tree encoding
`define FEAT_IDX_W  8
`define NODE_IDX_W  4
`define CLASS_W     3
`define NUM_NODES   11

`endif

//--- source/beatClassifierTop.sv
`timescale 1ns/1ps
`include "beat_macros.svh"

module beatClassifierTop (
    input  logic                clk,
    input  logic                rst,
    input  beatPkg::sampleT     sampleIn,
    output beatPkg::beatResultT result
);

    beatPkg::ramReqT        wrReq;
    beatPkg::ramReqT        rdReq;
    beatPkg::ramReqT        ramReq;
    logic                   rdGrant;
    logic                   windowReady;
    logic [`RAM_ADDR_W-1:0] windowBase;
    logic [`SAMPLE_W-1:0]   rdData;
    logic [`NODE_IDX_W-1:0] nodeIdx;
    beatPkg::treeNodeT      node;

    sampleWriter uWriter (
        .clk         (clk),
        .rst         (rst),
        .sampleIn    (sampleIn),
        .wrReq       (wrReq),
        .windowReady (windowReady),
        .windowBase  (windowBase)
    );

    ramArbiter uArbiter (
        .wrReq   (wrReq),
        .rdReq   (rdReq),
        .rdGrant (rdGrant),
        .ramReq  (ramReq)
    );

    windowRam uRam (
        .clk    (clk),
        .ramReq (ramReq),
        .rdData (rdData)
    );

    treeWalker uWalker (
        .clk         (clk),
        .rst         (rst),
        .windowReady (windowReady),
        .windowBase  (windowBase),
        .rdReq       (rdReq),
        .rdGrant     (rdGrant),
        .rdData      (rdData),
        .nodeIdx     (nodeIdx),
        .node        (node),
        .result      (result)
    );

    treeNodeRom uRom (
        .nodeIdx (nodeIdx),
        .node    (node)
    );

endmodule

//--- source/beatPkg.sv
`include "beat_macros.svh"

package beatPkg;

    typedef struct packed {
        logic                 valid;
        logic [`SAMPLE_W-1:0] value;
    } sampleT;

    typedef struct packed {
        logic                valid;
        logic [`CLASS_W-1:0] beatClass;
    } beatResultT;

    typedef struct packed {
        logic                   valid;
        logic                   write;
        logic [`RAM_ADDR_W-1:0] addr;
        logic [`SAMPLE_W-1:0]   data;
    } ramReqT;

    // Right child is always leftChild + 1
    typedef struct packed {
        logic [`FEAT_IDX_W-1:0] featIdx;
        logic [`SAMPLE_W-1:0]   threshold;
        logic [`NODE_IDX_W-1:0] leftChild;
    } splitNodeT;

    typedef struct packed {
        logic [`FEAT_IDX_W+`SAMPLE_W+`NODE_IDX_W-`CLASS_W-1:0] pad;
        logic [`CLASS_W-1:0]                                   beatClass;
    } leafNodeT;

    typedef union packed {
        splitNodeT split;
        leafNodeT  leaf;
    } treeNodeU;

    typedef struct packed {
        logic     isLeaf;
        treeNodeU body;
    } treeNodeT;

endpackage

//--- source/ramArbiter.sv
`timescale 1ns/1ps

module ramArbiter (
    input  beatPkg::ramReqT wrReq,
    input  beatPkg::ramReqT rdReq,
    output logic            rdGrant,
    output beatPkg::ramReqT ramReq
);

    // Writer has no back-pressure, so it always wins the port
    always_comb begin
        if (wrReq.valid) begin
            ramReq  = wrReq;
            rdGrant = 1'b0; // Walker retries next cycle
        end else begin
            ramReq       = rdReq;
            ramReq.write = 1'b0;
            rdGrant      = rdReq.valid;
        end
    end

endmodule

//--- source/sampleWriter.sv
`timescale 1ns/1ps
`include "beat_macros.svh"

module sampleWriter (
    input  logic                   clk,
    input  logic                   rst,
    input  beatPkg::sampleT        sampleIn,
    output beatPkg::ramReqT        wrReq,
    output logic                   windowReady,
    output logic [`RAM_ADDR_W-1:0] windowBase
);

    // Distance from the newest sample back to the oldest one in a window
    localparam logic [`RAM_ADDR_W-1:0] backSpan = `WINDOW_LEN - 1;

    logic [`RAM_ADDR_W-1:0] wrPtr;
    logic [`RAM_ADDR_W-1:0] fillCount;
    logic                   fullAfterWrite;

    assign fullAfterWrite = fillCount >= `WINDOW_LEN - 1;

    always_comb begin
        wrReq.valid = sampleIn.valid; // Same-cycle write request
        wrReq.write = 1'b1;
        wrReq.addr  = wrPtr;
        wrReq.data  = sampleIn.value;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wrPtr       <= '0;
            fillCount   <= '0;
            windowReady <= 1'b0;
        end else begin
            windowReady <= sampleIn.valid && fullAfterWrite;
            if (sampleIn.valid) begin
                wrPtr <= wrPtr + 1'b1; // Wraps at 256
                if (fillCount < `WINDOW_LEN) begin
                    fillCount <= fillCount + 1'b1; // Saturates at 187
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sampleIn.valid) begin
            windowBase <= wrPtr - backSpan;
        end
    end

endmodule

//--- source/treeNodeRom.sv
`timescale 1ns/1ps
`include "beat_macros.svh"

module treeNodeRom (
    input  logic [`NODE_IDX_W-1:0] nodeIdx,
    output beatPkg::treeNodeT      node
);

    beatPkg::treeNodeT nodeTable [`NUM_NODES];

    function automatic beatPkg::treeNodeT mkSplit(
        input logic [`FEAT_IDX_W-1:0] featIdx,
        input logic [`SAMPLE_W-1:0]   threshold,
        input logic [`NODE_IDX_W-1:0] leftChild
    );
        beatPkg::treeNodeT n;
        n.isLeaf                  = 1'b0;
        n.body.split.featIdx      = featIdx;
        n.body.split.threshold    = threshold;
        n.body.split.leftChild    = leftChild;
        return n;
    endfunction

    function automatic beatPkg::treeNodeT mkLeaf(input logic [`CLASS_W-1:0] beatClass);
        beatPkg::treeNodeT n;
        n                     = '0;
        n.isLeaf              = 1'b1;
        n.body.leaf.beatClass = beatClass;
        return n;
    endfunction

    always_comb begin
        nodeTable[0]  = mkSplit(8'd4, 13'd1610, 4'd1);
        nodeTable[1]  = mkSplit(8'd0, 13'd2385, 4'd3);
        nodeTable[2]  = mkSplit(8'd12, 13'd1214, 4'd5);
        nodeTable[3]  = mkSplit(8'd1, 13'd410, 4'd7);
        nodeTable[4]  = mkLeaf(3'd3); // Added so class 3 is reachable
        nodeTable[5]  = mkLeaf(3'd4);
        nodeTable[6]  = mkSplit(8'd3, 13'd2074, 4'd9);
        nodeTable[7]  = mkLeaf(3'd2);
        nodeTable[8]  = mkLeaf(3'd0);
        nodeTable[9]  = mkLeaf(3'd1);
        nodeTable[10] = mkLeaf(3'd0);
    end

    // Unused indices read back as a class-0 leaf
    assign node = (nodeIdx < `NUM_NODES) ? nodeTable[nodeIdx] : mkLeaf(3'd0);

endmodule

//--- source/treeWalker.sv
`timescale 1ns/1ps
`include "beat_macros.svh"

module treeWalker (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   windowReady,
    input  logic [`RAM_ADDR_W-1:0] windowBase,
    output beatPkg::ramReqT        rdReq,
    input  logic                   rdGrant,
    input  logic [`SAMPLE_W-1:0]   rdData,
    output logic [`NODE_IDX_W-1:0] nodeIdx,
    input  beatPkg::treeNodeT      node,
    output beatPkg::beatResultT    result
);

    typedef enum logic [1:0] {
        stIdle,
        stFetch,
        stWaitData,
        stDone
    } stateT;

    stateT                  state;
    logic [`RAM_ADDR_W-1:0] baseReg;
    logic [`CLASS_W-1:0]    classReg;
    logic                   goLeft;

    assign goLeft = rdData <= node.body.split.threshold; // Ties go left

    // Read request held until the arbiter grants it
    always_comb begin
        rdReq       = '0;
        rdReq.valid = (state == stFetch) && !node.isLeaf;
        rdReq.write = 1'b0;
        rdReq.addr  = baseReg + node.body.split.featIdx; // Wraps at 256
    end

    always_comb begin
        result.valid     = state == stDone;
        result.beatClass = classReg;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= stIdle;
            nodeIdx  <= '0;
            classReg <= '0;
        end else begin
            case (state)
                stIdle: begin
                    if (windowReady) begin
                        nodeIdx <= '0; // Start at the root
                        state   <= stFetch;
                    end
                end
                stFetch: begin
                    if (node.isLeaf) begin
                        classReg <= node.body.leaf.beatClass;
                        state    <= stDone;
                    end else if (rdGrant) begin
                        state <= stWaitData;
                    end
                end
                stWaitData: begin
                    if (goLeft) begin
                        nodeIdx <= node.body.split.leftChild;
                    end else begin
                        nodeIdx <= node.body.split.leftChild + 1'b1;
                    end
                    state <= stFetch;
                end
                stDone: begin
                    state <= stIdle; // Windows seen until here are dropped
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // Window base is captured only when a classification starts
    always_ff @(posedge clk) begin
        if (state == stIdle && windowReady) begin
            baseReg <= windowBase;
        end
    end

endmodule

//--- source/windowRam.sv
`timescale 1ns/1ps
`include "beat_macros.svh"

module windowRam (
    input  logic                 clk,
    input  beatPkg::ramReqT      ramReq,
    output logic [`SAMPLE_W-1:0] rdData
);

    logic [`SAMPLE_W-1:0] mem [0:(1 << `RAM_ADDR_W)-1];

    always_ff @(posedge clk) begin
        if (ramReq.valid) begin
            if (ramReq.write) begin
                mem[ramReq.addr] <= ramReq.data;
            end else begin
                rdData <= mem[ramReq.addr]; // Registered read
            end
        end
    end

endmodule

//--- test/beatClassifier_asserts.sv
`timescale 1ns/1ps

module beatClassifier_asserts (
    input logic                clk,
    input logic                rst,
    input beatPkg::ramReqT     wrReq,
    input logic                rdGrant,
    input beatPkg::beatResultT result
);

    int failCount;

    initial begin
        failCount = 0;
    end

    // Writer owns the RAM port whenever it asks for it
    grantVsWrite: assert property (@(posedge clk) disable iff (rst)
        !(rdGrant && wrReq.valid))
        else begin
            failCount++;
            $error("read granted while a write request is valid");
        end

    resultStrobe: assert property (@(posedge clk) disable iff (rst)
        result.valid |=> !result.valid)
        else begin
            failCount++;
            $error("result valid held high for two cycles");
        end

    resultRange: assert property (@(posedge clk) disable iff (rst)
        result.valid |-> result.beatClass <= 3'd4)
        else begin
            failCount++;
            $error("result class above 4");
        end

endmodule

bind beatClassifierTop beatClassifier_asserts uAsserts (
    .clk     (clk),
    .rst     (rst),
    .wrReq   (wrReq),
    .rdGrant (rdGrant),
    .result  (result)
);

//--- test/beatClassifier_tb.sv
`timescale 1ns/1ps
`include "beat_macros.svh"

module beatClassifier_tb;

    localparam int clkPeriod    = 100;
    localparam int resetCycles  = 10;
    localparam int waitLimit    = 200; // Cycles allowed for one result
    localparam int settleCycles = 24;  // Quiet time that must bring no extra result
    localparam int maxRecords   = 32;
    localparam int recordWords  = 8;

    logic                clk;
    logic                rst;
    beatPkg::sampleT     sampleIn;
    beatPkg::beatResultT result;

    logic [15:0]         stimMem [0:maxRecords*recordWords-1];
    logic [31:0]         lfsr;
    int                  resultCount;
    logic [`CLASS_W-1:0] lastClass;
    int                  pushedTotal;
    int                  errCount;
    int                  testsRun;
    int                  testsFailed;

    beatClassifierTop dut (
        .clk      (clk),
        .rst      (rst),
        .sampleIn (sampleIn),
        .result   (result)
    );

    always #(clkPeriod/2) clk = ~clk;

    // Result strobe is sampled mid-cycle
    always @(negedge clk) begin
        if (!rst && result.valid) begin
            resultCount <= resultCount + 1;
            lastClass   <= result.beatClass;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic takeBits(output logic [`SAMPLE_W-1:0] bits);
        int b;
        bits = '0;
        for (b = 0; b < `SAMPLE_W; b++) begin
            lfsr = lfsrNext(lfsr);
            bits = {bits[`SAMPLE_W-2:0], lfsr[0]};
        end
    endtask

    task automatic checkValue(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
            errCount++;
        end
    endtask

    task automatic finishTest(input string label, input int errBefore);
        testsRun++;
        if (errCount == errBefore) begin
            $display("Test %0d %s: passed", testsRun, label);
        end else begin
            testsFailed++;
            $display("Test %0d %s: failed", testsRun, label);
        end
    endtask

    // Called at a falling edge; strobe lasts one cycle
    task automatic pushSample(input logic [`SAMPLE_W-1:0] value);
        sampleIn.valid = 1'b1;
        sampleIn.value = value;
        @(negedge clk);
        sampleIn.valid = 1'b0;
        pushedTotal++;
    endtask

    task automatic pickSample(input int base, input int pos,
                              output logic [`SAMPLE_W-1:0] value);
        case (pos)
            0, 1, 2, 3, 4: value = stimMem[base + pos][`SAMPLE_W-1:0];
            12:            value = stimMem[base + 5][`SAMPLE_W-1:0];
            default:       takeBits(value);
        endcase
    endtask

    task automatic waitForResults(input int target);
        int cycles;
        cycles = 0;
        while (resultCount < target && cycles < waitLimit) begin
            @(posedge clk);
            cycles++;
        end
        assert (resultCount >= target) else begin
            $display("Timeout at %0t: result strobe did not arrive within %0d cycles",
                     $time, waitLimit);
            errCount++;
        end
    endtask

    task automatic runRecord(input int recIdx, input bit burst);
        logic [`SAMPLE_W-1:0] value;
        int                   base;
        int                   pos;
        int                   spacing;
        int                   expClass;
        int                   expResults;
        int                   startCount;
        int                   beforeLast;
        int                   errBefore;
        string                label;
        base       = recIdx * recordWords;
        spacing    = int'(stimMem[base + 6]);
        expClass   = int'(stimMem[base + 7]);
        expResults = 0;
        beforeLast = 0;
        errBefore  = errCount;
        @(negedge clk);
        startCount = resultCount;
        for (pos = 0; pos < `WINDOW_LEN; pos++) begin
            if (pushedTotal >= `WINDOW_LEN - 1) begin
                expResults++; // Window is full once this sample lands
            end
            pickSample(base, pos, value);
            if (pos == `WINDOW_LEN - 1) begin
                beforeLast = resultCount - startCount;
            end
            pushSample(value);
            if (pos < `WINDOW_LEN - 1) begin
                repeat (spacing - 1) @(negedge clk);
            end
        end
        if (burst) begin
            @(negedge clk);
            takeBits(value);
            pushSample(value); // Write collides with the walker's first read
        end
        waitForResults(startCount + expResults);
        repeat (settleCycles) @(posedge clk);
        checkValue("result count before last sample", beforeLast, expResults - 1);
        checkValue("result count", resultCount - startCount, expResults);
        checkValue("result.beatClass", lastClass, expClass);
        if (burst) begin
            label = $sformatf("burst on record %0d class %0d", recIdx, expClass);
        end else begin
            label = $sformatf("record %0d class %0d", recIdx, expClass);
        end
        finishTest(label, errBefore);
    endtask

    initial begin
        int a;
        int rec;
        int errBefore;
        clk         = 1'b0;
        rst         = 1'b1;
        sampleIn    = '0;
        lfsr        = 32'hd61e;
        resultCount = 0;
        lastClass   = '0;
        pushedTotal = 0;
        errCount    = 0;
        testsRun    = 0;
        testsFailed = 0;
        for (a = 0; a < maxRecords * recordWords; a++) begin
            stimMem[a] = 16'hffff; // End marker that no sample value can match
        end
        $readmemh("test/beat_stimulus.txt", stimMem);

        errBefore = errCount;
        repeat (resetCycles) @(negedge clk);
        checkValue("result.valid", result.valid, 0);
        rst = 1'b0;
        @(negedge clk);
        checkValue("result.valid", result.valid, 0);
        finishTest("reset", errBefore);

        rec = 0;
        while (rec < maxRecords && stimMem[rec * recordWords] != 16'hffff) begin
            runRecord(rec, 1'b0);
            rec++;
        end
        assert (rec > 0) else begin
            $display("No records were found in the stimulus file");
            errCount++;
        end
        runRecord(0, 1'b1);

        errCount = errCount + dut.uAsserts.failCount;
        $display("Tests run %0d, passed %0d, failed %0d, assertion failures %0d",
                 testsRun, testsRun - testsFailed, testsFailed, dut.uAsserts.failCount);
        if (errCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- test/beat_stimulus.txt
// Columns: feature 0, feature 1, feature 2, feature 3, feature 4, feature 12,
// spacing in cycles, expected class. All values hex, one record per line.
// One record per leaf: nodes 7, 8, 4, 5, 9 and 10
0300 0100 0555 0200 0400 0100 000c 0002
0500 0800 00aa 1fff 0010 1fff 000c 0000
0c00 0000 0123 0000 0000 0000 000e 0003
1fff 1fff 0000 1fff 1000 0200 000c 0004
0000 0000 00ff 0400 0800 0600 0010 0001
0100 0100 0100 1000 1fff 1fff 000c 0000
// Features equal to a threshold go left
0951 019a 0001 0000 064a 0000 000a 0002
0000 0000 0000 0000 064b 04be 000c 0004
0000 0000 0000 081a 1000 04bf 000c 0001
// One step past a threshold goes right
0952 0000 0000 0000 064a 0000 000c 0003
0951 019b 0000 0000 064a 0000 000c 0000
